/* hw/wb_host_pkg.sv */
`default_nettype none

package wb_host_pkg;

   //----------------------------------------------------------------------
   // bus geometry
   //----------------------------------------------------------------------
   localparam int WB_ADR_W      = 32;   // byte address
   localparam int WB_DAT_W      = 32;   // data path
   localparam int WB_SEL_W      = 4;    // one enable per byte

   // adr[23] high -> local register bank, low -> remote slave
   localparam int LOCAL_ADR_BIT = 23;

   // indirect msb for the remote side, {bank_sel, adr[23:0]}
   localparam int BANK_W        = 8;

   //----------------------------------------------------------------------
   // local register map
   //----------------------------------------------------------------------
   // word index taken from adr[3:2]
   localparam int REG_IDX_W     = 2;

   localparam logic [REG_IDX_W-1:0] REG_GLB_CTRL  = 2'd0; // global + clock ctrl
   localparam logic [REG_IDX_W-1:0] REG_BANK_SEL  = 2'd1; // 8 bit, zero extended
   localparam logic [REG_IDX_W-1:0] REG_CLK_CTRL1 = 2'd2;
   localparam logic [REG_IDX_W-1:0] REG_CLK_CTRL2 = 2'd3;

   //----------------------------------------------------------------------
   // global / clock control word
   //----------------------------------------------------------------------
   // software sees one 32 bit word, the clock block sees the fields
   //   [31:24] usb clock ctrl
   //   [23:20] cpu clock ctrl
   //   [19:12] rtc clock ctrl
   //   [11:8]  wb clock ctrl
   //   [7:0]   global ctrl, bit 0 is internal reset release
   typedef union packed {
      logic [WB_DAT_W-1:0] raw;    // as written / read back
      struct packed {
         logic [7:0] usb_clk;      // [7] div enable, [6:0] ratio
         logic [3:0] cpu_clk;      // [3] src sel, [2] div, [1:0] ratio
         logic [7:0] rtc_clk;      // divider ratio
         logic [3:0] wb_clk;       // same layout as cpu
         logic [7:0] glb;          // global controls
      } f;
   } glb_ctrl_t;

endpackage

`default_nettype wire

/* hw/wb_host_req.sv */
`timescale 1ns/1ps
`default_nettype none

// request side
// master strobe is registered so the rest of the bridge sees a
// multi-cycle request, then split once into local / remote
module wb_host_req (
   input  logic wbm_clk_i,     // bus clock
   input  logic wbm_rst_n,     // async, active low
   input  logic wbm_stb_i,     // raw master strobe
   input  logic local_bit_i,   // adr[23] of the held address
   input  logic resp_busy_i,   // response in flight, block new request
   output logic req_local_o,   // level, register bank access
   output logic req_remote_o   // level, slave port access
);

   logic stb_req_q;   // strobe, one cycle late
   logic req_live;    // request not yet answered

   //----------------------------------------------------------------------
   // stage 1, registered strobe
   //----------------------------------------------------------------------
   // while a response is on its way back the strobe is still high,
   // so it must not look like a new request
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         stb_req_q <= 1'b0;
      end
      else
      begin
         stb_req_q <= wbm_stb_i & !resp_busy_i;
      end
   end

   assign req_live = stb_req_q & !resp_busy_i;   // drop as soon as ack merges

   //----------------------------------------------------------------------
   // stage 2, classification
   //----------------------------------------------------------------------
   // address is held by the master for the whole access, so the
   // decode is stable while req_live is high
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         req_local_o  <= 1'b0;
         req_remote_o <= 1'b0;
      end
      else
      begin
         req_local_o  <= req_live &  local_bit_i;  // bank access
         req_remote_o <= req_live & !local_bit_i;  // forward to slave
      end
   end

   //----------------------------------------------------------------------
   // checks
   //----------------------------------------------------------------------
   // one target per access, the two paths share the master response
   a_req_onehot : assert property (
      @(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      !(req_local_o && req_remote_o)
   ) else $error("wb_host_req: local and remote request both active");

endmodule

`default_nettype wire

/* hw/wb_host_regs.sv */
`timescale 1ns/1ps
`default_nettype none

// local register bank
// four words behind adr[23], index from adr[3:2]
// global/clock ctrl, bank select, clock ctrl 1 and 2
module wb_host_regs
   import wb_host_pkg::*;
#(
   parameter logic [BANK_W-1:0] BANK_SEL_RST = 8'h10   // reset bank for remote msb
) (
   input  logic                 wbm_clk_i,     // bus clock
   input  logic                 wbm_rst_n,     // async, active low
   input  logic                 req_local_i,   // level from request side
   input  logic                 we_i,          // 1 write, 0 read
   input  logic [REG_IDX_W-1:0] reg_idx_i,     // word index
   input  logic [WB_DAT_W-1:0]  wdata_i,       // master write data
   output logic                 reg_ack_o,     // single cycle
   output logic [WB_DAT_W-1:0]  reg_rdata_o,   // captured with ack
   output logic [BANK_W-1:0]    bank_sel_o,    // remote address msb
   output glb_ctrl_t            glb_ctrl_o,    // global + clock ctrl word
   output logic [WB_DAT_W-1:0]  clk_ctrl1_o,
   output logic [WB_DAT_W-1:0]  clk_ctrl2_o
);

   logic                 acc_en;     // request seen, no ack yet
   logic                 wr_en;
   logic                 rd_en;
   logic [WB_DAT_W-1:0]  rd_mux;     // combinational read data

   //----------------------------------------------------------------------
   // access decode
   //----------------------------------------------------------------------
   // req_local stays high for the ack cycle too, so the pending ack
   // stops a second write / second pulse
   assign acc_en = req_local_i & !reg_ack_o;
   assign wr_en  = acc_en &  we_i;
   assign rd_en  = acc_en & !we_i;

   //----------------------------------------------------------------------
   // registers
   //----------------------------------------------------------------------
   // full word writes, byte enables are not looked at
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         glb_ctrl_o.raw <= '0;             // holds internal reset asserted
         bank_sel_o     <= BANK_SEL_RST;
         clk_ctrl1_o    <= '0;
         clk_ctrl2_o    <= '0;
      end
      else if (wr_en)
      begin
         case (reg_idx_i)
            REG_GLB_CTRL  : glb_ctrl_o.raw <= wdata_i;
            REG_BANK_SEL  : bank_sel_o     <= wdata_i[BANK_W-1:0];  // low byte only
            REG_CLK_CTRL1 : clk_ctrl1_o    <= wdata_i;
            REG_CLK_CTRL2 : clk_ctrl2_o    <= wdata_i;
            default       : ;
         endcase
      end
   end

   //----------------------------------------------------------------------
   // read back
   //----------------------------------------------------------------------
   always_comb
   begin
      rd_mux = '0;
      case (reg_idx_i)
         REG_GLB_CTRL  : rd_mux = glb_ctrl_o.raw;
         REG_BANK_SEL  : rd_mux = {{(WB_DAT_W-BANK_W){1'b0}}, bank_sel_o};
         REG_CLK_CTRL1 : rd_mux = clk_ctrl1_o;
         REG_CLK_CTRL2 : rd_mux = clk_ctrl2_o;
         default       : rd_mux = '0;
      endcase
   end

   //----------------------------------------------------------------------
   // acknowledge + read capture
   //----------------------------------------------------------------------
   // ack one cycle after req_local, data lands on the same edge
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         reg_ack_o   <= 1'b0;
         reg_rdata_o <= '0;
      end
      else
      begin
         reg_ack_o <= acc_en;              // write or read, same latency
         if (rd_en)
         begin
            reg_rdata_o <= rd_mux;         // hold until next read
         end
      end
   end

   //----------------------------------------------------------------------
   // checks
   //----------------------------------------------------------------------
   // a held local request must still give exactly one ack
   a_reg_ack_pulse : assert property (
      @(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      reg_ack_o |=> !reg_ack_o
   ) else $error("wb_host_regs: reg_ack held for more than one cycle");

endmodule

`default_nettype wire

/* hw/wb_host_fwd.sv */
`timescale 1ns/1ps
`default_nettype none

// forward / response side
// drives the slave port for remote requests, merges local and remote
// responses and registers them back to the master
module wb_host_fwd
   import wb_host_pkg::*;
(
   input  logic                wbm_clk_i,     // bus clock
   input  logic                wbm_rst_n,     // async, active low
   input  logic                req_remote_i,  // level from request side
   input  logic                wbm_cyc_i,
   input  logic                wbm_we_i,
   input  logic [WB_ADR_W-1:0] wbm_adr_i,
   input  logic [WB_DAT_W-1:0] wbm_dat_i,
   input  logic [WB_SEL_W-1:0] wbm_sel_i,
   input  logic [BANK_W-1:0]   bank_sel_i,    // indirect msb
   input  logic                reg_ack_i,     // local response
   input  logic [WB_DAT_W-1:0] reg_rdata_i,
   output logic                wbs_cyc_o,
   output logic                wbs_stb_o,
   output logic                wbs_we_o,
   output logic [WB_ADR_W-1:0] wbs_adr_o,
   output logic [WB_DAT_W-1:0] wbs_dat_o,
   output logic [WB_SEL_W-1:0] wbs_sel_o,
   input  logic [WB_DAT_W-1:0] wbs_dat_i,
   input  logic                wbs_ack_i,
   input  logic                wbs_err_i,
   output logic [WB_DAT_W-1:0] wbm_dat_o,     // holds last response data
   output logic                wbm_ack_o,
   output logic                wbm_err_o,
   output logic                resp_busy_o    // ends the request upstream
);

   logic                remote_done;   // slave terminated the cycle
   logic                mrg_ack;
   logic                mrg_err;
   logic [WB_DAT_W-1:0] mrg_dat;

   //----------------------------------------------------------------------
   // slave port
   //----------------------------------------------------------------------
   assign wbs_cyc_o = wbm_cyc_i;       // cycle passes straight through
   assign wbs_stb_o = req_remote_i;    // drops the cycle after ack
   assign wbs_we_o  = wbm_we_i;
   assign wbs_dat_o = wbm_dat_i;
   assign wbs_sel_o = wbm_sel_i;
   // more than 16MB behind the bridge, msb come from bank select
   assign wbs_adr_o = {bank_sel_i, wbm_adr_i[LOCAL_ADR_BIT:0]};

   //----------------------------------------------------------------------
   // response merge
   //----------------------------------------------------------------------
   assign remote_done = (wbs_ack_i | wbs_err_i) & req_remote_i;  // ignore stray acks
   assign mrg_ack     = reg_ack_i | remote_done;
   assign mrg_err     = !reg_ack_i & wbs_err_i & req_remote_i;   // local never errs
   assign mrg_dat     = reg_ack_i ? reg_rdata_i : wbs_dat_i;

   // merged ack now or registered ack last cycle
   assign resp_busy_o = mrg_ack | wbm_ack_o;

   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         wbm_ack_o <= 1'b0;
         wbm_err_o <= 1'b0;
         wbm_dat_o <= '0;
      end
      else
      begin
         wbm_ack_o <= mrg_ack;
         wbm_err_o <= mrg_err;
         if (mrg_ack)
         begin
            wbm_dat_o <= mrg_dat;          // keep last data on the bus
         end
      end
   end

   //----------------------------------------------------------------------
   // checks
   //----------------------------------------------------------------------
   a_stb_in_cyc : assert property (
      @(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      wbs_stb_o |-> wbs_cyc_o
   ) else $error("wb_host_fwd: slave strobe outside a bus cycle");

   a_err_with_ack : assert property (
      @(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      wbm_err_o |-> wbm_ack_o
   ) else $error("wb_host_fwd: master err without ack");

endmodule

`default_nettype wire

/* hw/wb_host.sv */
`timescale 1ns/1ps
`default_nettype none

// wishbone host bridge, single clock
// adr[23] high -> local registers, low -> slave port with banked msb
module wb_host
   import wb_host_pkg::*;
#(
   parameter logic [BANK_W-1:0] BANK_SEL_RST = 8'h10   // bank select after reset
) (
   input  logic                wbm_clk_i,          // bus clock
   input  logic                wbm_rst_n,          // async, active low

   // master port
   input  logic                wbm_cyc_i,
   input  logic                wbm_stb_i,
   input  logic                wbm_we_i,
   input  logic [WB_ADR_W-1:0] wbm_adr_i,
   input  logic [WB_DAT_W-1:0] wbm_dat_i,
   input  logic [WB_SEL_W-1:0] wbm_sel_i,
   output logic [WB_DAT_W-1:0] wbm_dat_o,
   output logic                wbm_ack_o,
   output logic                wbm_err_o,

   // slave port
   output logic                wbs_cyc_o,
   output logic                wbs_stb_o,
   output logic                wbs_we_o,
   output logic [WB_ADR_W-1:0] wbs_adr_o,
   output logic [WB_DAT_W-1:0] wbs_dat_o,
   output logic [WB_SEL_W-1:0] wbs_sel_o,
   input  logic [WB_DAT_W-1:0] wbs_dat_i,
   input  logic                wbs_ack_i,
   input  logic                wbs_err_i,

   // to the external clock / reset block
   output logic                wbd_int_rst_n_o,    // glb bit 0
   output logic [7:0]          cfg_glb_ctrl_o,
   output logic [3:0]          cfg_wb_clk_ctrl_o,
   output logic [7:0]          cfg_rtc_clk_ctrl_o,
   output logic [3:0]          cfg_cpu_clk_ctrl_o,
   output logic [7:0]          cfg_usb_clk_ctrl_o,
   output logic [WB_DAT_W-1:0] cfg_clk_ctrl1_o,
   output logic [WB_DAT_W-1:0] cfg_clk_ctrl2_o
);

   logic                req_local;
   logic                req_remote;
   logic                resp_busy;
   logic                reg_ack;
   logic [WB_DAT_W-1:0] reg_rdata;
   logic [BANK_W-1:0]   bank_sel;
   glb_ctrl_t           glb_ctrl;

   //----------------------------------------------------------------------
   // request side
   //----------------------------------------------------------------------
   wb_host_req u_req (
      .wbm_clk_i    (wbm_clk_i                ),
      .wbm_rst_n    (wbm_rst_n                ),
      .wbm_stb_i    (wbm_stb_i                ),
      .local_bit_i  (wbm_adr_i[LOCAL_ADR_BIT] ),  // target decode
      .resp_busy_i  (resp_busy                ),
      .req_local_o  (req_local                ),
      .req_remote_o (req_remote               )
   );

   //----------------------------------------------------------------------
   // local register bank
   //----------------------------------------------------------------------
   wb_host_regs #(
      .BANK_SEL_RST (BANK_SEL_RST)
   ) u_regs (
      .wbm_clk_i   (wbm_clk_i                  ),
      .wbm_rst_n   (wbm_rst_n                  ),
      .req_local_i (req_local                  ),
      .we_i        (wbm_we_i                   ),
      .reg_idx_i   (wbm_adr_i[REG_IDX_W+1:2]   ),  // word index
      .wdata_i     (wbm_dat_i                  ),
      .reg_ack_o   (reg_ack                    ),
      .reg_rdata_o (reg_rdata                  ),
      .bank_sel_o  (bank_sel                   ),
      .glb_ctrl_o  (glb_ctrl                   ),
      .clk_ctrl1_o (cfg_clk_ctrl1_o            ),
      .clk_ctrl2_o (cfg_clk_ctrl2_o            )
   );

   //----------------------------------------------------------------------
   // forward / response side
   //----------------------------------------------------------------------
   wb_host_fwd u_fwd (
      .wbm_clk_i    (wbm_clk_i  ),
      .wbm_rst_n    (wbm_rst_n  ),
      .req_remote_i (req_remote ),
      .wbm_cyc_i    (wbm_cyc_i  ),
      .wbm_we_i     (wbm_we_i   ),
      .wbm_adr_i    (wbm_adr_i  ),
      .wbm_dat_i    (wbm_dat_i  ),
      .wbm_sel_i    (wbm_sel_i  ),
      .bank_sel_i   (bank_sel   ),
      .reg_ack_i    (reg_ack    ),
      .reg_rdata_i  (reg_rdata  ),
      .wbs_cyc_o    (wbs_cyc_o  ),
      .wbs_stb_o    (wbs_stb_o  ),
      .wbs_we_o     (wbs_we_o   ),
      .wbs_adr_o    (wbs_adr_o  ),
      .wbs_dat_o    (wbs_dat_o  ),
      .wbs_sel_o    (wbs_sel_o  ),
      .wbs_dat_i    (wbs_dat_i  ),
      .wbs_ack_i    (wbs_ack_i  ),
      .wbs_err_i    (wbs_err_i  ),
      .wbm_dat_o    (wbm_dat_o  ),
      .wbm_ack_o    (wbm_ack_o  ),
      .wbm_err_o    (wbm_err_o  ),
      .resp_busy_o  (resp_busy  )
   );

   //----------------------------------------------------------------------
   // control word fields
   //----------------------------------------------------------------------
   assign cfg_glb_ctrl_o     = glb_ctrl.f.glb;
   assign cfg_wb_clk_ctrl_o  = glb_ctrl.f.wb_clk;
   assign cfg_rtc_clk_ctrl_o = glb_ctrl.f.rtc_clk;
   assign cfg_cpu_clk_ctrl_o = glb_ctrl.f.cpu_clk;
   assign cfg_usb_clk_ctrl_o = glb_ctrl.f.usb_clk;
   assign wbd_int_rst_n_o    = glb_ctrl.f.glb[0];   // low until software releases

endmodule

`default_nettype wire

/* tests/wb_host_slave_model.sv */
`timescale 1ns/1ps
`default_nettype none

// remote wishbone slave behind the bridge
// random wait states, 16 word memory on adr[5:2], error on adr[2] when enabled
module wb_host_slave_model
   import wb_host_pkg::*;
#(
   parameter int WAIT_MAX = 5   // longest wait before ack
) (
   input  logic                wbm_clk_i,
   input  logic                wbm_rst_n,
   input  logic                cyc_i,
   input  logic                stb_i,
   input  logic                we_i,
   input  logic [WB_ADR_W-1:0] adr_i,
   input  logic [WB_DAT_W-1:0] dat_i,
   input  logic [WB_SEL_W-1:0] sel_i,
   input  logic                err_en_i,    // error injection on
   output logic [WB_DAT_W-1:0] dat_o,
   output logic                ack_o,
   output logic                err_o,
   output logic [WB_ADR_W-1:0] log_adr_o,   // last access as seen on the port
   output logic [WB_DAT_W-1:0] log_dat_o,
   output logic [WB_SEL_W-1:0] log_sel_o,
   output logic                log_we_o,
   output int                  log_cnt_o    // accesses answered so far
);

   logic [WB_DAT_W-1:0] mem [0:15];   // word store
   logic                hit_err;
   int                  wait_n;

   initial
   begin
      dat_o     = '0;
      ack_o     = 1'b0;
      err_o     = 1'b0;
      log_adr_o = '0;
      log_dat_o = '0;
      log_sel_o = '0;
      log_we_o  = 1'b0;
      log_cnt_o = 0;
      forever
      begin
         @(posedge wbm_clk_i);
         #1;                                     // strobe settled after the edge
         if (wbm_rst_n && cyc_i && stb_i)
         begin
            wait_n = $urandom_range(WAIT_MAX, 0);
            repeat (wait_n)
            begin
               @(posedge wbm_clk_i);
               #1;
            end
            hit_err   = err_en_i & adr_i[2];
            log_adr_o = adr_i;
            log_dat_o = dat_i;
            log_sel_o = sel_i;
            log_we_o  = we_i;
            log_cnt_o = log_cnt_o + 1;
            if (we_i && !hit_err)
            begin
               mem[adr_i[5:2]] = dat_i;          // whole word, sel only logged
            end
            dat_o = mem[adr_i[5:2]];
            ack_o = 1'b1;                        // err rides on the ack
            err_o = hit_err;
            @(posedge wbm_clk_i);
            #1;
            ack_o = 1'b0;
            err_o = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* tests/tb_wb_host.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_wb_host
   import wb_host_pkg::*;
();

   localparam int          SEED        = 14;
   localparam int          WAIT_MAX    = 5;              // slave wait states 0..5
   localparam int          TIMEOUT_CYC = 2000;           // ~60 accesses x 8 cycles, x4
   localparam logic [31:0] LOCAL_BASE  = 32'h0080_0000;  // adr[23] set

   logic                wbm_clk_i, wbm_rst_n;
   logic                wbm_cyc_i, wbm_stb_i, wbm_we_i;
   logic [WB_ADR_W-1:0] wbm_adr_i, wbs_adr_o, log_adr;
   logic [WB_DAT_W-1:0] wbm_dat_i, wbm_dat_o, wbs_dat_o, wbs_dat_i, log_dat;
   logic [WB_SEL_W-1:0] wbm_sel_i, wbs_sel_o, log_sel;
   logic                wbm_ack_o, wbm_err_o, wbs_ack_i, wbs_err_i;
   logic                wbs_cyc_o, wbs_stb_o, wbs_we_o, log_we, err_en;
   logic                wbd_int_rst_n_o;
   logic [7:0]          cfg_glb_ctrl_o, cfg_rtc_clk_ctrl_o, cfg_usb_clk_ctrl_o;
   logic [3:0]          cfg_wb_clk_ctrl_o, cfg_cpu_clk_ctrl_o;
   logic [WB_DAT_W-1:0] cfg_clk_ctrl1_o, cfg_clk_ctrl2_o;
   int                  log_cnt;

   int                  fail_cnt  = 0;   // every failed check
   int                  err_mark  = 0;   // fail_cnt when the current test began
   int                  tests_ok  = 0;
   int                  tests_bad = 0;
   int                  cycles    = 0;
   int                  i;
   int                  cnt0;
   logic                remote_ok = 1'b0;  // remote access in flight
   logic                rerr;
   logic [31:0]         wval, rdat, adr;
   logic [7:0]          bank;
   logic [3:0]          sel;
   logic [31:0]         exp_mem [0:15];   // expected slave contents

   wb_host #(
      .BANK_SEL_RST (8'h10)
   ) dut0 (.*);

   wb_host_slave_model #(
      .WAIT_MAX (WAIT_MAX)
   ) u_slave (
      .wbm_clk_i (wbm_clk_i),
      .wbm_rst_n (wbm_rst_n),
      .cyc_i     (wbs_cyc_o),
      .stb_i     (wbs_stb_o),
      .we_i      (wbs_we_o ),
      .adr_i     (wbs_adr_o),
      .dat_i     (wbs_dat_o),
      .sel_i     (wbs_sel_o),
      .err_en_i  (err_en   ),
      .dat_o     (wbs_dat_i),
      .ack_o     (wbs_ack_i),
      .err_o     (wbs_err_i),
      .log_adr_o (log_adr  ),
      .log_dat_o (log_dat  ),
      .log_sel_o (log_sel  ),
      .log_we_o  (log_we   ),
      .log_cnt_o (log_cnt  )
   );

   initial
   begin
      wbm_clk_i = 1'b0;
      forever #5 wbm_clk_i = ~wbm_clk_i;   // 100 MHz
   end

   // --------------------------------------------------------------------
   // checking helpers
   // --------------------------------------------------------------------
   task automatic report_error(input string msg);
      $display("error %0t: %s", $time, msg);
      fail_cnt++;
   endtask

   task automatic check_equal(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      a_value : assert (got === exp)
      else report_error($sformatf("%s, got %h expected %h", what, got, exp));
   endtask

   task automatic finish_test(input string name);
      if (fail_cnt == err_mark)
      begin
         tests_ok++;
         $display("test %s: ok", name);
      end
      else
      begin
         tests_bad++;
         $display("test %s: failed with %0d errors", name, fail_cnt - err_mark);
      end
      err_mark = fail_cnt;
   endtask

   // one master access, inputs held until ack, strobe dropped the cycle after
   task automatic bus_access(input logic we, input logic [31:0] adr_a,
                             input logic [31:0] wdat, input logic [3:0] sel_a,
                             output logic [31:0] rd, output logic er);
      int waits;
      waits = 0;
      @(posedge wbm_clk_i);
      #1;
      remote_ok = !adr_a[LOCAL_ADR_BIT];
      wbm_cyc_i = 1'b1;
      wbm_stb_i = 1'b1;
      wbm_we_i  = we;
      wbm_adr_i = adr_a;
      wbm_dat_i = wdat;
      wbm_sel_i = sel_a;
      @(negedge wbm_clk_i);                   // first negedge is before edge 0
      while (!wbm_ack_o)
      begin
         waits++;
         @(negedge wbm_clk_i);
      end
      rd = wbm_dat_o;
      er = wbm_err_o;
      if (adr_a[LOCAL_ADR_BIT])
      begin
         check_equal("local ack latency", waits - 1, 3);   // edge 0 to ack edge
         check_equal("local err", er, 1'b0);
      end
      @(posedge wbm_clk_i);
      #1;
      wbm_cyc_i = 1'b0;
      wbm_stb_i = 1'b0;
      wbm_we_i  = 1'b0;
      remote_ok = 1'b0;
   endtask

   // --------------------------------------------------------------------
   // bus protocol checks
   // --------------------------------------------------------------------
   a_ack_pulse : assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      wbm_ack_o |=> !wbm_ack_o)
   else report_error("wbm_ack_o high for more than one cycle");

   a_err_ack : assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      wbm_err_o |-> wbm_ack_o)
   else report_error("wbm_err_o without wbm_ack_o");

   a_remote_lat : assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      (wbs_ack_i && wbs_stb_o) |=> wbm_ack_o)
   else report_error("wbm_ack_o not one cycle after wbs_ack_i");

   a_dat_hold : assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      !wbm_ack_o |-> $stable(wbm_dat_o))
   else report_error("wbm_dat_o changed without ack");

   a_no_stray_stb : assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      wbs_stb_o |-> remote_ok)
   else report_error("slave strobe outside a remote access");

   // slave cycle tracks the master cycle
   a_cyc_follow : assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      wbs_cyc_o == wbm_cyc_i)
   else report_error("wbs_cyc_o does not follow wbm_cyc_i");

   always @(posedge wbm_clk_i)
   begin
      cycles++;
      if (cycles >= TIMEOUT_CYC)
      begin
         $display("timeout, the run did not end within %0d cycles", TIMEOUT_CYC);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // --------------------------------------------------------------------
   // test sequence
   // --------------------------------------------------------------------
   initial
   begin
      void'($urandom(SEED));
      wbm_rst_n = 1'b0;
      wbm_cyc_i = 1'b0;
      wbm_stb_i = 1'b0;
      wbm_we_i  = 1'b0;
      wbm_adr_i = '0;
      wbm_dat_i = '0;
      wbm_sel_i = '0;
      err_en    = 1'b0;
      repeat (4) @(posedge wbm_clk_i);
      #1;
      wbm_rst_n = 1'b1;

      // reset values, bank select comes up as 0x10
      for (i = 0; i < 4; i++)
      begin
         bus_access(1'b0, LOCAL_BASE | (i << 2), '0, 4'hf, rdat, rerr);
         check_equal("reset value", rdat, (i == 1) ? 32'h10 : 32'h0);
      end
      check_equal("cfg glb", cfg_glb_ctrl_o, '0);
      check_equal("cfg clocks", {cfg_usb_clk_ctrl_o, cfg_cpu_clk_ctrl_o,
                  cfg_rtc_clk_ctrl_o, cfg_wb_clk_ctrl_o}, '0);
      check_equal("cfg clk ctrl", cfg_clk_ctrl1_o | cfg_clk_ctrl2_o, '0);
      check_equal("internal reset", wbd_int_rst_n_o, 1'b0);
      check_equal("slave accesses after reset", log_cnt, 0);
      finish_test("reset values");

      for (i = 0; i < 4; i++)
      begin
         wval = $urandom;
         bus_access(1'b1, LOCAL_BASE | (i << 2), wval, 4'hf, rdat, rerr);
         bus_access(1'b0, LOCAL_BASE | (i << 2), '0, 4'hf, rdat, rerr);
         check_equal("register readback", rdat, (i == 1) ? {24'h0, wval[7:0]} : wval);
      end
      finish_test("local write and readback");

      for (i = 0; i < 2; i++)
      begin
         wval    = $urandom;
         wval[0] = i[0];                       // internal reset both ways
         bus_access(1'b1, LOCAL_BASE, wval, 4'hf, rdat, rerr);
         check_equal("usb clk field", cfg_usb_clk_ctrl_o, wval[31:24]);
         check_equal("cpu clk field", cfg_cpu_clk_ctrl_o, wval[23:20]);
         check_equal("rtc clk field", cfg_rtc_clk_ctrl_o, wval[19:12]);
         check_equal("wb clk field", cfg_wb_clk_ctrl_o, wval[11:8]);
         check_equal("glb field", cfg_glb_ctrl_o, wval[7:0]);
         check_equal("internal reset", wbd_int_rst_n_o, wval[0]);
      end
      finish_test("control word decode");

      wval = $urandom;
      bank = wval[7:0];
      bus_access(1'b1, LOCAL_BASE | {REG_BANK_SEL, 2'b00}, wval, 4'hf, rdat, rerr);
      for (i = 0; i < 8; i++)
      begin
         adr       = $urandom;
         adr[23]   = 1'b0;
         adr[5:2]  = i[3:0];                   // one slave word each
         adr[1:0]  = 2'b00;
         wval      = $urandom;
         sel       = 4'($urandom_range(15, 1));
         cnt0      = log_cnt;
         exp_mem[i] = wval;
         bus_access(1'b1, adr, wval, sel, rdat, rerr);
         check_equal("slave address", log_adr, {bank, adr[23:0]});
         check_equal("slave data", log_dat, wval);
         check_equal("slave sel", log_sel, sel);
         check_equal("slave we", log_we, 1'b1);
         check_equal("slave access count", log_cnt, cnt0 + 1);
         check_equal("remote write err", rerr, 1'b0);
      end
      finish_test("remote write");

      for (i = 0; i < 8; i++)
      begin
         adr      = $urandom;
         adr[23]  = 1'b0;
         adr[5:2] = i[3:0];
         adr[1:0] = 2'b00;
         bus_access(1'b0, adr, '0, 4'hf, rdat, rerr);
         check_equal("remote read data", rdat, exp_mem[i]);
         repeat (2) @(negedge wbm_clk_i);
         check_equal("read data held", wbm_dat_o, exp_mem[i]);
      end
      finish_test("remote read");

      err_en = 1'b1;
      for (i = 0; i < 4; i++)
      begin
         adr      = $urandom;
         adr[23]  = 1'b0;
         adr[5:2] = i[3:0];                    // odd words hit the error bit
         adr[1:0] = 2'b00;
         bus_access(i[0], adr, $urandom, 4'hf, rdat, rerr);
         check_equal("remote err", rerr, adr[2]);
      end
      err_en = 1'b0;
      bus_access(1'b0, LOCAL_BASE | 32'h4, '0, 4'hf, rdat, rerr);  // err checked inside
      finish_test("remote error");

      $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, fail_cnt);
      if (fail_cnt == 0)
      begin
         $display("TESTBENCH PASSED");
      end
      else
      begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* wb_host.f */
hw/wb_host_pkg.sv
hw/wb_host_req.sv
hw/wb_host_regs.sv
hw/wb_host_fwd.sv
hw/wb_host.sv
tests/wb_host_slave_model.sv
tests/tb_wb_host.sv
